// ==== source/cpu_defs.svh ====
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// instruction register fields.
`define CPU_OPCODE_W 6
`define CPU_FUNCT_W 6

// control path encodings.
`define CTRL_ALU_OP_W 3
`define CTRL_SHIFT_OP_W 3

// 25 states in use, room for 32.
`define CTRL_STATE_W 5

`endif

// ==== source/cpu_isa_pkg.sv ====
`include "cpu_defs.svh"

package cpu_isa_pkg;

	typedef enum logic [`CPU_OPCODE_W-1:0] {
		op_r_type = 6'b000000,
		op_addi   = 6'b001000,
		op_addiu  = 6'b001001,
		op_beq    = 6'b000100,
		op_bne    = 6'b000101,
		op_ble    = 6'b000110,
		op_bgt    = 6'b000111,
		op_j      = 6'b000010,
		op_jal    = 6'b000011
	} opcode_e;

	// only meaningful when the opcode is r_type.
	typedef enum logic [`CPU_FUNCT_W-1:0] {
		fn_sll  = 6'b000000,
		fn_srl  = 6'b000010,
		fn_sra  = 6'b000011,
		fn_sllv = 6'b000100,
		fn_srav = 6'b000111,
		fn_jr   = 6'b001000,
		fn_add  = 6'b100000,
		fn_sub  = 6'b100010,
		fn_and  = 6'b100100,
		fn_slt  = 6'b101010
	} funct_e;

	typedef enum logic [3:0] {
		class_add,
		class_sub,
		class_and,
		class_slt,
		class_shift_imm,
		class_shift_reg,
		class_imm_add,
		class_branch_eq, // beq and bne.
		class_branch_gt, // ble and bgt.
		class_jump,
		class_jal,
		class_jr,
		class_illegal
	} instr_class_e;

endpackage

// ==== source/ctrl_pkg.sv ====
`include "cpu_defs.svh"

package ctrl_pkg;

	typedef enum logic [`CTRL_STATE_W-1:0] {
		fetch_1,
		fetch_2,
		fetch_3,
		decode_1,
		decode_2,
		alu_add,
		alu_sub,
		alu_and,
		alu_writeback,
		slt,
		shift_load_shamt,
		shift_load_reg,
		shift_left,
		shift_right_arith,
		shift_right_logic,
		shift_writeback,
		imm_alu,
		imm_writeback,
		branch_1,
		branch_2,
		jal_1,
		jal_2,
		jump,
		jump_reg,
		close
	} state_e;

	typedef enum logic [`CTRL_ALU_OP_W-1:0] {
		op_load    = 3'b000,
		op_add     = 3'b001,
		op_sub     = 3'b010,
		op_and     = 3'b011,
		op_inc     = 3'b100,
		op_not     = 3'b101,
		op_xor     = 3'b110,
		op_compare = 3'b111 // sets eq, gt and lt flags.
	} alu_op_e;

	typedef enum logic [`CTRL_SHIFT_OP_W-1:0] {
		sh_nop          = 3'b000,
		sh_load         = 3'b001,
		sh_left_arith   = 3'b010,
		sh_right_logic  = 3'b011,
		sh_right_arith  = 3'b100,
		sh_rotate_right = 3'b101,
		sh_rotate_left  = 3'b110
	} shift_op_e;

	typedef enum logic [1:0] {
		src_b_reg,
		src_b_four,
		src_b_sign_imm,
		src_b_branch_offset // sign_imm shifted left by two.
	} alu_src_b_e;

	typedef enum logic [2:0] {
		wb_alu_out = 3'b000,
		wb_compare = 3'b100,
		wb_shift   = 3'b101
	} wb_src_e;

	typedef enum logic [1:0] {
		dst_rt = 2'b00,
		dst_ra = 2'b01,
		dst_rd = 2'b11
	} reg_dst_e;

	typedef enum logic [1:0] {
		pc_alu_result,
		pc_alu_out,
		pc_jump_target
	} pc_src_e;

	typedef enum logic [1:0] {
		amt_register = 2'b00,
		amt_shamt    = 2'b10
	} shift_amt_e;

endpackage

// ==== source/instr_decoder.sv ====
`timescale 1ns/10ps

module instr_decoder (
	input  cpu_isa_pkg::opcode_e      i_op_code,
	input  cpu_isa_pkg::funct_e       i_funct,
	output cpu_isa_pkg::instr_class_e o_instr_class
);

	cpu_isa_pkg::instr_class_e funct_class;

	// r_type classes come from funct alone.
	always_comb begin
		case (i_funct)
			cpu_isa_pkg::fn_add: funct_class = cpu_isa_pkg::class_add;
			cpu_isa_pkg::fn_sub: funct_class = cpu_isa_pkg::class_sub;
			cpu_isa_pkg::fn_and: funct_class = cpu_isa_pkg::class_and;
			cpu_isa_pkg::fn_slt: funct_class = cpu_isa_pkg::class_slt;
			cpu_isa_pkg::fn_sll,
			cpu_isa_pkg::fn_srl,
			cpu_isa_pkg::fn_sra: begin
				funct_class = cpu_isa_pkg::class_shift_imm; // amount from shamt.
			end
			cpu_isa_pkg::fn_sllv,
			cpu_isa_pkg::fn_srav: begin
				funct_class = cpu_isa_pkg::class_shift_reg; // amount from rs.
			end
			cpu_isa_pkg::fn_jr: funct_class = cpu_isa_pkg::class_jr;
			default: funct_class = cpu_isa_pkg::class_illegal;
		endcase
	end

	always_comb begin
		case (i_op_code)
			cpu_isa_pkg::op_r_type: o_instr_class = funct_class;
			cpu_isa_pkg::op_addi,
			cpu_isa_pkg::op_addiu: begin
				o_instr_class = cpu_isa_pkg::class_imm_add; // no overflow trap.
			end
			cpu_isa_pkg::op_beq,
			cpu_isa_pkg::op_bne: begin
				o_instr_class = cpu_isa_pkg::class_branch_eq;
			end
			cpu_isa_pkg::op_ble,
			cpu_isa_pkg::op_bgt: begin
				o_instr_class = cpu_isa_pkg::class_branch_gt;
			end
			cpu_isa_pkg::op_j: o_instr_class = cpu_isa_pkg::class_jump;
			cpu_isa_pkg::op_jal: o_instr_class = cpu_isa_pkg::class_jal;
			default: o_instr_class = cpu_isa_pkg::class_illegal;
		endcase
	end

endmodule

// ==== source/ctrl_sequencer.sv ====
`timescale 1ns/10ps

module ctrl_sequencer (
	input  logic                      clock,
	input  logic                      reset,
	input  cpu_isa_pkg::instr_class_e i_instr_class,
	input  cpu_isa_pkg::funct_e       i_funct,
	output ctrl_pkg::state_e          o_state
);

	ctrl_pkg::state_e state_q;
	ctrl_pkg::state_e state_d;

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q <= ctrl_pkg::fetch_1;
		end else begin
			state_q <= state_d;
		end
	end

	always_comb begin
		state_d = ctrl_pkg::close;
		case (state_q)
			ctrl_pkg::fetch_1: state_d = ctrl_pkg::fetch_2;
			ctrl_pkg::fetch_2: state_d = ctrl_pkg::fetch_3;
			ctrl_pkg::fetch_3: state_d = ctrl_pkg::decode_1;
			ctrl_pkg::decode_1: state_d = ctrl_pkg::decode_2;

			ctrl_pkg::decode_2: begin
				case (i_instr_class)
					cpu_isa_pkg::class_add: state_d = ctrl_pkg::alu_add;
					cpu_isa_pkg::class_sub: state_d = ctrl_pkg::alu_sub;
					cpu_isa_pkg::class_and: state_d = ctrl_pkg::alu_and;
					cpu_isa_pkg::class_slt: state_d = ctrl_pkg::slt;
					cpu_isa_pkg::class_shift_imm: state_d = ctrl_pkg::shift_load_shamt;
					cpu_isa_pkg::class_shift_reg: state_d = ctrl_pkg::shift_load_reg;
					cpu_isa_pkg::class_imm_add: state_d = ctrl_pkg::imm_alu;
					cpu_isa_pkg::class_branch_eq,
					cpu_isa_pkg::class_branch_gt: begin
						state_d = ctrl_pkg::branch_1; // condition is resolved in the encoder.
					end
					cpu_isa_pkg::class_jump: state_d = ctrl_pkg::jump;
					cpu_isa_pkg::class_jal: state_d = ctrl_pkg::jal_1;
					cpu_isa_pkg::class_jr: state_d = ctrl_pkg::jump_reg;
					default: state_d = ctrl_pkg::close; // illegal, nothing written.
				endcase
			end

			ctrl_pkg::alu_add,
			ctrl_pkg::alu_sub,
			ctrl_pkg::alu_and: begin
				state_d = ctrl_pkg::alu_writeback;
			end

			// register and shamt variants share the operation states.
			ctrl_pkg::shift_load_shamt,
			ctrl_pkg::shift_load_reg: begin
				case (i_funct)
					cpu_isa_pkg::fn_sll,
					cpu_isa_pkg::fn_sllv: state_d = ctrl_pkg::shift_left;
					cpu_isa_pkg::fn_sra,
					cpu_isa_pkg::fn_srav: state_d = ctrl_pkg::shift_right_arith;
					cpu_isa_pkg::fn_srl: state_d = ctrl_pkg::shift_right_logic;
					default: state_d = ctrl_pkg::close;
				endcase
			end

			ctrl_pkg::shift_left,
			ctrl_pkg::shift_right_arith,
			ctrl_pkg::shift_right_logic: begin
				state_d = ctrl_pkg::shift_writeback;
			end

			ctrl_pkg::imm_alu: state_d = ctrl_pkg::imm_writeback;
			ctrl_pkg::branch_1: state_d = ctrl_pkg::branch_2;
			ctrl_pkg::jal_1: state_d = ctrl_pkg::jal_2;
			ctrl_pkg::jal_2: state_d = ctrl_pkg::jump; // link written, then jump.

			ctrl_pkg::alu_writeback,
			ctrl_pkg::slt,
			ctrl_pkg::shift_writeback,
			ctrl_pkg::imm_writeback,
			ctrl_pkg::branch_2,
			ctrl_pkg::jump,
			ctrl_pkg::jump_reg: begin
				state_d = ctrl_pkg::close;
			end

			ctrl_pkg::close: state_d = ctrl_pkg::fetch_1;
			default: state_d = ctrl_pkg::fetch_1;
		endcase
	end

	assign o_state = state_q;

endmodule

// ==== source/ctrl_signal_encoder.sv ====
`timescale 1ns/10ps

module ctrl_signal_encoder (
	input  logic                   clock,
	input  logic                   reset,
	input  ctrl_pkg::state_e       i_state,
	input  cpu_isa_pkg::opcode_e   i_op_code,
	input  logic                   i_equal,
	input  logic                   i_greater,
	output logic                   o_ir_write,
	output logic                   o_pc_write,
	output logic                   o_a_b_write,
	output logic                   o_reg_write,
	output logic                   o_alu_out_write,
	output logic                   o_shift_src,
	output logic                   o_alu_src_a,
	output ctrl_pkg::alu_src_b_e   o_alu_src_b,
	output ctrl_pkg::alu_op_e      o_alu_op,
	output ctrl_pkg::wb_src_e      o_wb_src,
	output ctrl_pkg::reg_dst_e     o_reg_dst,
	output ctrl_pkg::pc_src_e      o_pc_src,
	output ctrl_pkg::shift_op_e    o_shift_op,
	output ctrl_pkg::shift_amt_e   o_shift_amt
);

	logic                 branch_taken;
	logic                 ir_write_d, pc_write_d, a_b_write_d, reg_write_d;
	logic                 alu_out_write_d, shift_src_d, alu_src_a_d;
	ctrl_pkg::alu_src_b_e alu_src_b_d;
	ctrl_pkg::alu_op_e    alu_op_d;
	ctrl_pkg::wb_src_e    wb_src_d;
	ctrl_pkg::reg_dst_e   reg_dst_d;
	ctrl_pkg::pc_src_e    pc_src_d;
	ctrl_pkg::shift_op_e  shift_op_d;
	ctrl_pkg::shift_amt_e shift_amt_d;

	always_comb begin
		case (i_op_code)
			cpu_isa_pkg::op_beq: branch_taken = i_equal;
			cpu_isa_pkg::op_bne: branch_taken = !i_equal;
			cpu_isa_pkg::op_bgt: branch_taken = i_greater;
			cpu_isa_pkg::op_ble: branch_taken = !i_greater;
			default: branch_taken = 1'b0;
		endcase
	end

	always_comb begin
		ir_write_d = 1'b0;
		pc_write_d = 1'b0;
		a_b_write_d = 1'b0;
		reg_write_d = 1'b0;
		alu_out_write_d = 1'b0;
		shift_src_d = 1'b0;
		alu_src_a_d = 1'b0; // pc.
		alu_src_b_d = ctrl_pkg::src_b_reg;
		alu_op_d = ctrl_pkg::op_load;
		wb_src_d = ctrl_pkg::wb_alu_out;
		reg_dst_d = ctrl_pkg::dst_rt;
		pc_src_d = ctrl_pkg::pc_alu_result;
		shift_op_d = ctrl_pkg::sh_nop;
		shift_amt_d = ctrl_pkg::amt_register;
		case (i_state)
			ctrl_pkg::fetch_1, ctrl_pkg::fetch_2, ctrl_pkg::fetch_3: begin
				alu_op_d = ctrl_pkg::op_add; // pc + 4.
				alu_src_b_d = ctrl_pkg::src_b_four;
				pc_write_d = (i_state == ctrl_pkg::fetch_2);
				ir_write_d = (i_state == ctrl_pkg::fetch_3);
			end
			ctrl_pkg::decode_1: begin
				alu_op_d = ctrl_pkg::op_add; // branch target into alu_out.
				alu_src_b_d = ctrl_pkg::src_b_branch_offset;
				a_b_write_d = 1'b1;
				alu_out_write_d = 1'b1;
			end
			ctrl_pkg::decode_2: alu_op_d = ctrl_pkg::op_add;
			ctrl_pkg::alu_add, ctrl_pkg::alu_sub, ctrl_pkg::alu_and: begin
				alu_src_a_d = 1'b1;
				alu_out_write_d = 1'b1;
				if (i_state == ctrl_pkg::alu_add) begin
					alu_op_d = ctrl_pkg::op_add;
				end else if (i_state == ctrl_pkg::alu_sub) begin
					alu_op_d = ctrl_pkg::op_sub;
				end else begin
					alu_op_d = ctrl_pkg::op_and;
				end
			end
			ctrl_pkg::alu_writeback: begin
				reg_write_d = 1'b1;
				reg_dst_d = ctrl_pkg::dst_rd;
			end
			ctrl_pkg::slt: begin
				alu_src_a_d = 1'b1;
				alu_op_d = ctrl_pkg::op_compare;
				reg_write_d = 1'b1; // lt flag straight to rd.
				reg_dst_d = ctrl_pkg::dst_rd;
				wb_src_d = ctrl_pkg::wb_compare;
			end
			ctrl_pkg::shift_load_shamt: begin
				shift_op_d = ctrl_pkg::sh_load;
				shift_src_d = 1'b1;
				shift_amt_d = ctrl_pkg::amt_shamt;
			end
			ctrl_pkg::shift_load_reg: shift_op_d = ctrl_pkg::sh_load;
			ctrl_pkg::shift_left: shift_op_d = ctrl_pkg::sh_left_arith;
			ctrl_pkg::shift_right_arith: shift_op_d = ctrl_pkg::sh_right_arith;
			ctrl_pkg::shift_right_logic: shift_op_d = ctrl_pkg::sh_right_logic;
			ctrl_pkg::shift_writeback: begin
				reg_write_d = 1'b1;
				reg_dst_d = ctrl_pkg::dst_rd;
				wb_src_d = ctrl_pkg::wb_shift;
			end
			ctrl_pkg::imm_alu: begin
				alu_src_a_d = 1'b1;
				alu_src_b_d = ctrl_pkg::src_b_sign_imm;
				alu_op_d = ctrl_pkg::op_add;
				alu_out_write_d = 1'b1;
			end
			ctrl_pkg::imm_writeback: reg_write_d = 1'b1;
			ctrl_pkg::branch_1, ctrl_pkg::branch_2: begin
				alu_src_a_d = 1'b1;
				alu_op_d = ctrl_pkg::op_compare;
				pc_src_d = ctrl_pkg::pc_alu_out; // target computed in decode_1.
				pc_write_d = (i_state == ctrl_pkg::branch_2) && branch_taken;
			end
			ctrl_pkg::jal_1: alu_out_write_d = 1'b1; // return address.
			ctrl_pkg::jal_2: begin
				reg_write_d = 1'b1;
				reg_dst_d = ctrl_pkg::dst_ra;
			end
			ctrl_pkg::jump: begin
				pc_write_d = 1'b1;
				pc_src_d = ctrl_pkg::pc_jump_target;
			end
			ctrl_pkg::jump_reg: begin
				pc_write_d = 1'b1;
				alu_src_a_d = 1'b1; // rs passes through the alu.
			end
			default: ;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			o_ir_write <= 1'b0;
			o_pc_write <= 1'b0;
			o_a_b_write <= 1'b0;
			o_reg_write <= 1'b0;
			o_alu_out_write <= 1'b0;
			o_shift_src <= 1'b0;
			o_alu_src_a <= 1'b0;
			o_alu_src_b <= ctrl_pkg::src_b_reg;
			o_alu_op <= ctrl_pkg::op_load;
			o_wb_src <= ctrl_pkg::wb_alu_out;
			o_reg_dst <= ctrl_pkg::dst_rt;
			o_pc_src <= ctrl_pkg::pc_alu_result;
			o_shift_op <= ctrl_pkg::sh_nop;
			o_shift_amt <= ctrl_pkg::amt_register;
		end else begin
			o_ir_write <= ir_write_d;
			o_pc_write <= pc_write_d;
			o_a_b_write <= a_b_write_d;
			o_reg_write <= reg_write_d;
			o_alu_out_write <= alu_out_write_d;
			o_shift_src <= shift_src_d;
			o_alu_src_a <= alu_src_a_d;
			o_alu_src_b <= alu_src_b_d;
			o_alu_op <= alu_op_d;
			o_wb_src <= wb_src_d;
			o_reg_dst <= reg_dst_d;
			o_pc_src <= pc_src_d;
			o_shift_op <= shift_op_d;
			o_shift_amt <= shift_amt_d;
		end
	end

endmodule

// ==== source/ctrl_unit.sv ====
`timescale 1ns/10ps
`include "cpu_defs.svh"

module ctrl_unit (
	input  logic                      clock,
	input  logic                      reset,
	input  logic [`CPU_OPCODE_W-1:0]  i_op_code,
	input  logic [`CPU_FUNCT_W-1:0]   i_funct,
	input  logic                      i_equal,
	input  logic                      i_greater,
	output logic                      o_ir_write,
	output logic                      o_pc_write,
	output logic                      o_a_b_write,
	output logic                      o_reg_write,
	output logic                      o_alu_out_write,
	output logic                      o_shift_src,
	output logic                      o_alu_src_a,
	output ctrl_pkg::alu_src_b_e      o_alu_src_b,
	output ctrl_pkg::alu_op_e         o_alu_op,
	output ctrl_pkg::wb_src_e         o_wb_src,
	output ctrl_pkg::reg_dst_e        o_reg_dst,
	output ctrl_pkg::pc_src_e         o_pc_src,
	output ctrl_pkg::shift_op_e       o_shift_op,
	output ctrl_pkg::shift_amt_e      o_shift_amt
);

	cpu_isa_pkg::instr_class_e instr_class;
	ctrl_pkg::state_e          state;

	instr_decoder instr_decoder_i (
		.i_op_code     (cpu_isa_pkg::opcode_e'(i_op_code)), // raw ir field.
		.i_funct       (cpu_isa_pkg::funct_e'(i_funct)),
		.o_instr_class (instr_class)
	);

	ctrl_sequencer ctrl_sequencer_i (
		.clock         (clock),
		.reset         (reset),
		.i_instr_class (instr_class),
		.i_funct       (cpu_isa_pkg::funct_e'(i_funct)),
		.o_state       (state)
	);

	ctrl_signal_encoder ctrl_signal_encoder_i (
		.clock           (clock),
		.reset           (reset),
		.i_state         (state),
		.i_op_code       (cpu_isa_pkg::opcode_e'(i_op_code)),
		.i_equal         (i_equal),
		.i_greater       (i_greater),
		.o_ir_write      (o_ir_write),
		.o_pc_write      (o_pc_write),
		.o_a_b_write     (o_a_b_write),
		.o_reg_write     (o_reg_write),
		.o_alu_out_write (o_alu_out_write),
		.o_shift_src     (o_shift_src),
		.o_alu_src_a     (o_alu_src_a),
		.o_alu_src_b     (o_alu_src_b),
		.o_alu_op        (o_alu_op),
		.o_wb_src        (o_wb_src),
		.o_reg_dst       (o_reg_dst),
		.o_pc_src        (o_pc_src),
		.o_shift_op      (o_shift_op),
		.o_shift_amt     (o_shift_amt)
	);

endmodule

// ==== tb/ctrl_unit_model.svh ====
`ifndef CTRL_UNIT_MODEL_SVH
`define CTRL_UNIT_MODEL_SVH

// class from the opcode, and from funct for r_type.
function automatic cpu_isa_pkg::instr_class_e classify_instr(
	input logic [`CPU_OPCODE_W-1:0] op,
	input logic [`CPU_FUNCT_W-1:0]  fn
);
	cpu_isa_pkg::instr_class_e cls;
	cls = cpu_isa_pkg::class_illegal;
	case (op)
		cpu_isa_pkg::op_addi, cpu_isa_pkg::op_addiu: cls = cpu_isa_pkg::class_imm_add;
		cpu_isa_pkg::op_beq, cpu_isa_pkg::op_bne: cls = cpu_isa_pkg::class_branch_eq;
		cpu_isa_pkg::op_ble, cpu_isa_pkg::op_bgt: cls = cpu_isa_pkg::class_branch_gt;
		cpu_isa_pkg::op_j: cls = cpu_isa_pkg::class_jump;
		cpu_isa_pkg::op_jal: cls = cpu_isa_pkg::class_jal;
		cpu_isa_pkg::op_r_type: begin
			case (fn)
				cpu_isa_pkg::fn_add: cls = cpu_isa_pkg::class_add;
				cpu_isa_pkg::fn_sub: cls = cpu_isa_pkg::class_sub;
				cpu_isa_pkg::fn_and: cls = cpu_isa_pkg::class_and;
				cpu_isa_pkg::fn_slt: cls = cpu_isa_pkg::class_slt;
				cpu_isa_pkg::fn_sll, cpu_isa_pkg::fn_srl,
				cpu_isa_pkg::fn_sra: cls = cpu_isa_pkg::class_shift_imm;
				cpu_isa_pkg::fn_sllv,
				cpu_isa_pkg::fn_srav: cls = cpu_isa_pkg::class_shift_reg;
				cpu_isa_pkg::fn_jr: cls = cpu_isa_pkg::class_jr;
				default: cls = cpu_isa_pkg::class_illegal;
			endcase
		end
		default: cls = cpu_isa_pkg::class_illegal;
	endcase
	return cls;
endfunction

// cycles from one ir write to the next.
function automatic int instr_length(input cpu_isa_pkg::instr_class_e cls);
	case (cls)
		cpu_isa_pkg::class_slt, cpu_isa_pkg::class_jump,
		cpu_isa_pkg::class_jr: instr_length = 7;
		cpu_isa_pkg::class_shift_imm, cpu_isa_pkg::class_shift_reg,
		cpu_isa_pkg::class_jal: instr_length = 9;
		cpu_isa_pkg::class_illegal: instr_length = 6;
		default: instr_length = 8; // alu ops, immediate add, branches.
	endcase
endfunction

function automatic ctrl_pkg::alu_op_e alu_op_of_class(input cpu_isa_pkg::instr_class_e cls);
	case (cls)
		cpu_isa_pkg::class_add, cpu_isa_pkg::class_imm_add: alu_op_of_class = ctrl_pkg::op_add;
		cpu_isa_pkg::class_sub: alu_op_of_class = ctrl_pkg::op_sub;
		cpu_isa_pkg::class_and: alu_op_of_class = ctrl_pkg::op_and;
		default: alu_op_of_class = ctrl_pkg::op_load;
	endcase
endfunction

function automatic ctrl_pkg::shift_op_e shift_op_of_funct(input logic [`CPU_FUNCT_W-1:0] fn);
	case (fn)
		cpu_isa_pkg::fn_sll, cpu_isa_pkg::fn_sllv: shift_op_of_funct = ctrl_pkg::sh_left_arith;
		cpu_isa_pkg::fn_sra, cpu_isa_pkg::fn_srav: shift_op_of_funct = ctrl_pkg::sh_right_arith;
		cpu_isa_pkg::fn_srl: shift_op_of_funct = ctrl_pkg::sh_right_logic;
		default: shift_op_of_funct = ctrl_pkg::sh_nop;
	endcase
endfunction

// register writes of a class and the selects they use.
function automatic int reg_writes_of_class(
	input  cpu_isa_pkg::instr_class_e cls,
	output ctrl_pkg::wb_src_e         wb,
	output ctrl_pkg::reg_dst_e        dst
);
	wb = ctrl_pkg::wb_alu_out;
	dst = ctrl_pkg::dst_rd;
	reg_writes_of_class = 1;
	case (cls)
		cpu_isa_pkg::class_slt: wb = ctrl_pkg::wb_compare;
		cpu_isa_pkg::class_shift_imm, cpu_isa_pkg::class_shift_reg: wb = ctrl_pkg::wb_shift;
		cpu_isa_pkg::class_imm_add: dst = ctrl_pkg::dst_rt;
		cpu_isa_pkg::class_jal: dst = ctrl_pkg::dst_ra;
		cpu_isa_pkg::class_add, cpu_isa_pkg::class_sub, cpu_isa_pkg::class_and: ;
		default: reg_writes_of_class = 0;
	endcase
endfunction

// pc writes after decode, with the branch decision.
function automatic int pc_writes_of_instr(
	input  cpu_isa_pkg::instr_class_e cls,
	input  logic [`CPU_OPCODE_W-1:0]  op,
	input  logic                      eq,
	input  logic                      gt,
	output ctrl_pkg::pc_src_e         src
);
	src = ctrl_pkg::pc_alu_out;
	pc_writes_of_instr = 0;
	case (cls)
		cpu_isa_pkg::class_branch_eq: pc_writes_of_instr = (op == cpu_isa_pkg::op_beq) ? eq : !eq;
		cpu_isa_pkg::class_branch_gt: pc_writes_of_instr = (op == cpu_isa_pkg::op_bgt) ? gt : !gt;
		cpu_isa_pkg::class_jump, cpu_isa_pkg::class_jal: begin
			src = ctrl_pkg::pc_jump_target;
			pc_writes_of_instr = 1;
		end
		cpu_isa_pkg::class_jr: begin
			src = ctrl_pkg::pc_alu_result;
			pc_writes_of_instr = 1;
		end
		default: ;
	endcase
endfunction

`endif

// ==== tb/ctrl_unit_tb.sv ====
`timescale 1ns/10ps
`include "cpu_defs.svh"

module ctrl_unit_tb;

	logic                       clock = 1'b0;
	logic                       reset;
	logic [`CPU_OPCODE_W-1:0]   i_op_code;
	logic [`CPU_FUNCT_W-1:0]    i_funct;
	logic                       i_equal;
	logic                       i_greater;
	logic                       o_ir_write, o_pc_write, o_a_b_write, o_reg_write;
	logic                       o_alu_out_write, o_shift_src, o_alu_src_a;
	ctrl_pkg::alu_src_b_e       o_alu_src_b;
	ctrl_pkg::alu_op_e          o_alu_op;
	ctrl_pkg::wb_src_e          o_wb_src;
	ctrl_pkg::reg_dst_e         o_reg_dst;
	ctrl_pkg::pc_src_e          o_pc_src;
	ctrl_pkg::shift_op_e        o_shift_op;
	ctrl_pkg::shift_amt_e       o_shift_amt;

	logic [31:0] rng_state = 32'h3c33_e2e4;
	int          checks = 0;
	int          errors = 0;
	bit          hung = 1'b0;

	localparam logic [8*`CPU_OPCODE_W-1:0] kept_ops = {
		cpu_isa_pkg::op_addi, cpu_isa_pkg::op_addiu, cpu_isa_pkg::op_beq, cpu_isa_pkg::op_bne,
		cpu_isa_pkg::op_ble, cpu_isa_pkg::op_bgt, cpu_isa_pkg::op_j, cpu_isa_pkg::op_jal
	};
	localparam logic [10*`CPU_FUNCT_W-1:0] kept_functs = {
		cpu_isa_pkg::fn_add, cpu_isa_pkg::fn_sub, cpu_isa_pkg::fn_and, cpu_isa_pkg::fn_slt,
		cpu_isa_pkg::fn_sll, cpu_isa_pkg::fn_srl, cpu_isa_pkg::fn_sra, cpu_isa_pkg::fn_sllv,
		cpu_isa_pkg::fn_srav, cpu_isa_pkg::fn_jr
	};

	`include "ctrl_unit_model.svh"

	ctrl_unit ctrl_unit_i (.*);

	always #10 clock = ~clock;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic record_compare(input string sig, input string got, input string exp,
		input bit same);
		checks++;
		if (!same) begin
			errors++;
			$display("** Error at %0t: %s is %s, expected %s", $time, sig, got, exp);
		end
	endtask

	task automatic check_bit(input string sig, input logic got, input logic exp);
		record_compare(sig, $sformatf("%b", got), $sformatf("%b", exp), got === exp);
	endtask

	task automatic check_count(input string sig, input int got, input int exp);
		record_compare(sig, $sformatf("%0d", got), $sformatf("%0d", exp), got == exp);
	endtask

	task automatic check_alu_op(input ctrl_pkg::alu_op_e got, input ctrl_pkg::alu_op_e exp);
		record_compare("o_alu_op", got.name(), exp.name(), got === exp);
	endtask

	task automatic check_src_b(input ctrl_pkg::alu_src_b_e got, input ctrl_pkg::alu_src_b_e exp);
		record_compare("o_alu_src_b", got.name(), exp.name(), got === exp);
	endtask

	task automatic check_shift_op(input ctrl_pkg::shift_op_e got, input ctrl_pkg::shift_op_e exp);
		record_compare("o_shift_op", got.name(), exp.name(), got === exp);
	endtask

	task automatic check_shift_amt(input ctrl_pkg::shift_amt_e got,
		input ctrl_pkg::shift_amt_e exp);
		record_compare("o_shift_amt", got.name(), exp.name(), got === exp);
	endtask

	task automatic check_pc_src(input ctrl_pkg::pc_src_e got, input ctrl_pkg::pc_src_e exp);
		record_compare("o_pc_src", got.name(), exp.name(), got === exp);
	endtask

	task automatic check_wb(input ctrl_pkg::wb_src_e got_src, input ctrl_pkg::wb_src_e exp_src,
		input ctrl_pkg::reg_dst_e got_dst, input ctrl_pkg::reg_dst_e exp_dst);
		record_compare("o_wb_src", got_src.name(), exp_src.name(), got_src === exp_src);
		record_compare("o_reg_dst", got_dst.name(), exp_dst.name(), got_dst === exp_dst);
	endtask

	// mostly kept instructions, some with a random opcode or funct.
	task automatic pick_instruction(output logic [5:0] op, output logic [5:0] fn);
		rng_state = xorshift32(rng_state);
		op = rng_state[3] ? cpu_isa_pkg::op_r_type : kept_ops[rng_state[10:8] * 6 +: 6];
		fn = kept_functs[(rng_state[19:16] % 10) * 6 +: 6];
		if (rng_state[2:0] == 3'd0) begin
			op = rng_state[29:24];
		end else if (rng_state[2:0] == 3'd1) begin
			fn = rng_state[29:24];
		end
	endtask

	// drives one instruction and watches it up to the next ir write.
	task automatic run_instruction(input int num);
		logic [5:0]                op;
		logic [5:0]                fn;
		logic                      eq;
		logic                      gt;
		cpu_isa_pkg::instr_class_e cls;
		ctrl_pkg::wb_src_e         exp_wb;
		ctrl_pkg::reg_dst_e        exp_dst;
		ctrl_pkg::pc_src_e         exp_pc;
		ctrl_pkg::shift_amt_e      exp_amt;
		int                        exp_reg_writes, exp_pc_writes, exp_shift_steps, exp_alu_writes;
		int                        cycles, reg_writes, pc_writes, shift_steps, errors_before;
		int                        alu_writes;
		pick_instruction(op, fn);
		eq = rng_state[14];
		gt = rng_state[22];
		cls = classify_instr(op, fn);
		exp_reg_writes = reg_writes_of_class(cls, exp_wb, exp_dst);
		exp_pc_writes = pc_writes_of_instr(cls, op, eq, gt, exp_pc);
		exp_shift_steps = (cls == cpu_isa_pkg::class_shift_imm ||
			cls == cpu_isa_pkg::class_shift_reg) ? 2 : 0;
		exp_amt = (cls == cpu_isa_pkg::class_shift_imm) ? ctrl_pkg::amt_shamt
			: ctrl_pkg::amt_register;
		exp_alu_writes = (alu_op_of_class(cls) != ctrl_pkg::op_load) ? 1 : 0;
		errors_before = errors;
		cycles = 0;
		reg_writes = 0;
		pc_writes = 0;
		shift_steps = 0;
		alu_writes = 0;
		@(posedge clock);
		i_op_code <= op;
		i_funct <= fn;
		i_equal <= eq;
		i_greater <= gt;
		do begin
			@(negedge clock);
			cycles++;
			if (o_reg_write) begin
				reg_writes++;
				check_wb(o_wb_src, exp_wb, o_reg_dst, exp_dst);
			end
			// fetch also writes the pc, with pc + 4.
			if (o_pc_write && o_alu_src_b != ctrl_pkg::src_b_four) begin
				pc_writes++;
				check_pc_src(o_pc_src, exp_pc);
			end
			// a_b_write marks the decode word.
			if (o_alu_out_write && !o_a_b_write && alu_op_of_class(cls) != ctrl_pkg::op_load) begin
				alu_writes++;
				check_alu_op(o_alu_op, alu_op_of_class(cls));
				if (cls == cpu_isa_pkg::class_imm_add) begin
					check_src_b(o_alu_src_b, ctrl_pkg::src_b_sign_imm);
				end
			end
			if (o_shift_op != ctrl_pkg::sh_nop) begin
				if (shift_steps == 0) begin
					check_shift_op(o_shift_op, ctrl_pkg::sh_load);
					check_shift_amt(o_shift_amt, exp_amt);
				end else begin
					check_shift_op(o_shift_op, shift_op_of_funct(fn));
				end
				shift_steps++;
			end
		end while (!o_ir_write && cycles < 20);
		if (!o_ir_write) begin
			hung = 1'b1;
			$display("test %0d: no o_ir_write pulse within 20 cycles", num);
		end else begin
			check_count("cycles", cycles, instr_length(cls));
			check_count("o_reg_write pulses", reg_writes, exp_reg_writes);
			check_count("o_pc_write pulses", pc_writes, exp_pc_writes);
			check_count("o_shift_op steps", shift_steps, exp_shift_steps);
			check_count("o_alu_out_write pulses", alu_writes, exp_alu_writes);
			$display("test %0d: %s op %b funct %b, %0d cycles, %s", num, cls.name(), op, fn,
				cycles, (errors == errors_before) ? "ok" : "failed");
		end
	endtask

	initial begin
		int cycles;
		int num;
		reset = 1'b1;
		i_op_code = '0;
		i_funct = '0;
		i_equal = 1'b0;
		i_greater = 1'b0;
		repeat (3) @(posedge clock);
		@(negedge clock);
		check_bit("o_ir_write", o_ir_write, 1'b0);
		check_bit("o_pc_write", o_pc_write, 1'b0);
		check_bit("o_a_b_write", o_a_b_write, 1'b0);
		check_bit("o_reg_write", o_reg_write, 1'b0);
		check_bit("o_alu_out_write", o_alu_out_write, 1'b0);
		check_bit("o_shift_src", o_shift_src, 1'b0);
		check_bit("o_alu_src_a", o_alu_src_a, 1'b0);
		check_src_b(o_alu_src_b, ctrl_pkg::src_b_reg);
		check_alu_op(o_alu_op, ctrl_pkg::op_load);
		check_wb(o_wb_src, ctrl_pkg::wb_alu_out, o_reg_dst, ctrl_pkg::dst_rt);
		check_pc_src(o_pc_src, ctrl_pkg::pc_alu_result);
		check_shift_op(o_shift_op, ctrl_pkg::sh_nop);
		check_shift_amt(o_shift_amt, ctrl_pkg::amt_register);
		$display("test 0: reset values, %s", (errors == 0) ? "ok" : "failed");
		@(posedge clock);
		reset <= 1'b0;
		cycles = 0;
		do begin
			@(negedge clock);
			cycles++;
		end while (!o_ir_write && cycles < 20);
		if (!o_ir_write) begin
			hung = 1'b1;
			$display("no o_ir_write pulse within 20 cycles after reset");
		end
		for (num = 1; num <= 300 && !hung; num++) begin
			run_instruction(num);
		end
		$display("%0d tests, %0d checks, %0d errors", num, checks, errors);
		if (hung || errors != 0) begin
			$display("Finished with errors");
		end else begin
			$display("Finished with no errors");
		end
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+source
+incdir+tb
source/cpu_isa_pkg.sv
source/ctrl_pkg.sv
source/instr_decoder.sv
source/ctrl_sequencer.sv
source/ctrl_signal_encoder.sv
source/ctrl_unit.sv
tb/ctrl_unit_tb.sv
